// ==== source/dma_cfg_pkg.sv ====
// DMA configuration constants
// Register map, TCDM address window and descriptor queue sizing
package dma_cfg_pkg;

  // Register word offset
  typedef logic [2:0] reg_addr_t;

  // ------------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------------
  localparam reg_addr_t REG_SRC        = 3'd0;
  localparam reg_addr_t REG_DST        = 3'd1;
  localparam reg_addr_t REG_LEN        = 3'd2;
  localparam reg_addr_t REG_SRC_STRIDE = 3'd3;
  localparam reg_addr_t REG_DST_STRIDE = 3'd4;
  localparam reg_addr_t REG_REPS       = 3'd5;
  // Read to launch, returns the new id or 0 when the queue is full
  localparam reg_addr_t REG_NEXT_ID    = 3'd6;
  localparam reg_addr_t REG_DONE_ID    = 3'd7;

  // ------------------------------------------------------------------
  // Address map, word addresses
  // ------------------------------------------------------------------
  localparam logic [31:0] TCDM_BASE = 32'h1C00_0000;
  localparam logic [31:0] TCDM_SIZE = 32'h0001_0000;

  // Entries of the 2D descriptor FIFO
  localparam int unsigned QUEUE_DEPTH = 4;

endpackage : dma_cfg_pkg

// ==== source/dma_xfer_pkg.sv ====
// DMA transfer types
// Word, length and id widths plus the midend and backend FSM states
package dma_xfer_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [15:0] len_t;
  typedef logic [15:0] reps_t;
  typedef logic [15:0] id_t;

  // 2D midend
  typedef enum logic [1:0] {
    MID_IDLE,
    MID_ISSUE,
    MID_WAIT
  } mid_state_e;

  // Copy backend, one read and one write per word
  typedef enum logic [1:0] {
    BE_IDLE,
    BE_READ,
    BE_WRITE,
    BE_DONE
  } be_state_e;

endpackage : dma_xfer_pkg

// ==== source/dma_reg_frontend.sv ====
`timescale 1ns/1ps

// DMA register frontend
// Holds the programmed 2D transfer and launches it on a read of REG_NEXT_ID
module dma_reg_frontend
  import dma_cfg_pkg::*, dma_xfer_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      reg_wr_i,
  input  logic      reg_rd_i,
  input  reg_addr_t reg_addr_i,
  input  data_t     reg_wdata_i,
  output data_t     reg_rdata_o,
  output addr_t     desc_src_o,
  output addr_t     desc_dst_o,
  output addr_t     desc_src_stride_o,
  output addr_t     desc_dst_stride_o,
  output len_t      desc_len_o,
  output reps_t     desc_reps_o,
  output id_t       desc_id_o,
  output logic      desc_valid_o,
  input  logic      desc_ready_i,
  input  logic      done_i,
  input  id_t       done_id_i
);

  addr_t src_q, dst_q, src_stride_q, dst_stride_q;
  len_t  len_q;
  reps_t reps_q;
  id_t   next_id_q;
  id_t   done_id_q;
  logic  launch_ok;
  logic  launch;

  // A descriptor waiting for its push edge blocks a second launch
  assign launch_ok = desc_ready_i & ~desc_valid_o;
  assign launch    = reg_rd_i & (reg_addr_i == REG_NEXT_ID) & launch_ok;

  // Programmable transfer registers
  always_ff @(posedge clk_i) begin
    if (reg_wr_i) begin
      case (reg_addr_i)
        REG_SRC:        src_q        <= reg_wdata_i;
        REG_DST:        dst_q        <= reg_wdata_i;
        REG_LEN:        len_q        <= len_t'(reg_wdata_i);
        REG_SRC_STRIDE: src_stride_q <= reg_wdata_i;
        REG_DST_STRIDE: dst_stride_q <= reg_wdata_i;
        REG_REPS:       reps_q       <= reps_t'(reg_wdata_i);
        default: ;
      endcase
    end
  end

  // Launch pulse, id counter and completion id
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      desc_valid_o <= 1'b0;
      next_id_q    <= id_t'(1);
      done_id_q    <= '0;
    end else begin
      desc_valid_o <= launch;
      if (launch) begin
        next_id_q <= next_id_q + 1'b1;
      end
      if (done_i) begin
        done_id_q <= done_id_i;
      end
    end
  end

  // Snapshot so later writes do not disturb the queued transfer
  always_ff @(posedge clk_i) begin
    if (launch) begin
      desc_src_o        <= src_q;
      desc_dst_o        <= dst_q;
      desc_src_stride_o <= src_stride_q;
      desc_dst_stride_o <= dst_stride_q;
      desc_len_o        <= len_q;
      desc_reps_o       <= reps_q;
      desc_id_o         <= next_id_q;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (reg_rd_i) begin
      case (reg_addr_i)
        REG_SRC:        reg_rdata_o = src_q;
        REG_DST:        reg_rdata_o = dst_q;
        REG_LEN:        reg_rdata_o = data_t'(len_q);
        REG_SRC_STRIDE: reg_rdata_o = src_stride_q;
        REG_DST_STRIDE: reg_rdata_o = dst_stride_q;
        REG_REPS:       reg_rdata_o = data_t'(reps_q);
        REG_NEXT_ID:    reg_rdata_o = launch_ok ? data_t'(next_id_q) : '0;
        REG_DONE_ID:    reg_rdata_o = data_t'(done_id_q);
      endcase
    end
  end

  // Queue space seen at launch must still be there at the push
  assert property (@(posedge clk_i) disable iff (rst_i)
    desc_valid_o |-> desc_ready_i);

endmodule : dma_reg_frontend

// ==== source/dma_req_queue.sv ====
`timescale 1ns/1ps

// 2D descriptor FIFO between the register frontend and the midend
module dma_req_queue
  import dma_cfg_pkg::*, dma_xfer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  addr_t in_src_i, in_dst_i, in_src_stride_i, in_dst_stride_i,
  input  len_t  in_len_i,
  input  reps_t in_reps_i,
  input  id_t   in_id_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output addr_t out_src_o, out_dst_o, out_src_stride_o, out_dst_stride_o,
  output len_t  out_len_o,
  output reps_t out_reps_o,
  output id_t   out_id_o,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output logic  empty_o
);

  localparam int unsigned PtrW  = $clog2(QUEUE_DEPTH);
  localparam int unsigned DescW = 4 * $bits(addr_t) + $bits(len_t) + $bits(reps_t)
                                  + $bits(id_t);

  logic [DescW-1:0] mem_q [QUEUE_DEPTH];
  logic [PtrW-1:0]  wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]    count_q;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count_q == (PtrW+1)'(QUEUE_DEPTH));
  assign empty_o     = (count_q == '0);
  assign in_ready_o  = ~full;
  assign out_valid_o = ~empty_o;
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  // Head entry drives the output directly
  assign {out_src_o, out_dst_o, out_src_stride_o, out_dst_stride_o,
          out_len_o, out_reps_o, out_id_o} = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {in_src_i, in_dst_i, in_src_stride_i, in_dst_stride_i,
                          in_len_i, in_reps_i, in_id_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + (PtrW+1)'(push) - (PtrW+1)'(pop);
    end
  end

  // The frontend never offers a descriptor to a full FIFO
  assert property (@(posedge clk_i) disable iff (rst_i) in_valid_i |-> !full);

  // Pointers meet only when empty or full, else a pop ran past the tail
  assert property (@(posedge clk_i) disable iff (rst_i)
    (rd_ptr_q == wr_ptr_q) |-> (empty_o || full));

endmodule : dma_req_queue

// ==== source/dma_2d_midend.sv ====
`timescale 1ns/1ps

// 2D midend
// Splits a 2D descriptor into strided 1D bursts, one per repetition
module dma_2d_midend
  import dma_xfer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  addr_t nd_src_i, nd_dst_i, nd_src_stride_i, nd_dst_stride_i,
  input  len_t  nd_len_i,
  input  reps_t nd_reps_i,
  input  id_t   nd_id_i,
  input  logic  nd_valid_i,
  output logic  nd_ready_o,
  output addr_t burst_src_o,
  output addr_t burst_dst_o,
  output len_t  burst_len_o,
  output logic  burst_valid_o,
  input  logic  burst_ready_i,
  input  logic  burst_done_i,
  output logic  xfer_done_o,
  output id_t   xfer_id_o,
  output logic  idle_o
);

  mid_state_e state_q;
  reps_t      reps_left_q;
  addr_t      src_stride_q;
  addr_t      dst_stride_q;

  assign nd_ready_o    = (state_q == MID_IDLE);
  assign idle_o        = (state_q == MID_IDLE);
  assign burst_valid_o = (state_q == MID_ISSUE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= MID_IDLE;
      reps_left_q <= '0;
      xfer_done_o <= 1'b0;
    end else begin
      xfer_done_o <= 1'b0;
      case (state_q)
        MID_IDLE: begin
          if (nd_valid_i) begin
            // Zero repetitions still move one burst
            reps_left_q <= (nd_reps_i == '0) ? reps_t'(1) : nd_reps_i;
            state_q     <= MID_ISSUE;
          end
        end
        MID_ISSUE: begin
          if (burst_ready_i) begin
            reps_left_q <= reps_left_q - 1'b1;
            if (reps_left_q == reps_t'(1)) begin
              state_q <= MID_WAIT;
            end
          end
        end
        // Only the last burst is still running here
        MID_WAIT: begin
          if (burst_done_i) begin
            xfer_done_o <= 1'b1;
            state_q     <= MID_IDLE;
          end
        end
        default: state_q <= MID_IDLE;
      endcase
    end
  end

  // Running addresses step by the strides on each accepted burst
  always_ff @(posedge clk_i) begin
    if (nd_ready_o && nd_valid_i) begin
      burst_src_o  <= nd_src_i;
      burst_dst_o  <= nd_dst_i;
      burst_len_o  <= nd_len_i;
      src_stride_q <= nd_src_stride_i;
      dst_stride_q <= nd_dst_stride_i;
      xfer_id_o    <= nd_id_i;
    end else if (burst_valid_o && burst_ready_i) begin
      burst_src_o <= burst_src_o + src_stride_q;
      burst_dst_o <= burst_dst_o + dst_stride_q;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) xfer_done_o |=> !xfer_done_o);

endmodule : dma_2d_midend

// ==== source/dma_copy_backend.sv ====
`timescale 1ns/1ps

// DMA copy backend
// Moves one 1D burst word by word, a read cycle followed by a write cycle
module dma_copy_backend
  import dma_xfer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  addr_t req_src_i,
  input  addr_t req_dst_i,
  input  len_t  req_len_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  output logic  done_o,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  input  data_t mem_rdata_i,
  output logic  idle_o
);

  be_state_e state_q;
  len_t      left_q;
  addr_t     src_q;
  addr_t     dst_q;

  assign req_ready_o = (state_q == BE_IDLE);
  assign idle_o      = (state_q == BE_IDLE);
  assign done_o      = (state_q == BE_DONE);

  // Memory access path
  assign mem_req_o  = (state_q == BE_READ) || (state_q == BE_WRITE);
  assign mem_we_o   = (state_q == BE_WRITE);
  assign mem_addr_o = mem_we_o ? dst_q : src_q;
  // Read data lands in the write cycle and is written back right away
  assign mem_wdata_o = mem_rdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= BE_IDLE;
      left_q  <= '0;
    end else begin
      case (state_q)
        BE_IDLE: begin
          if (req_valid_i) begin
            left_q  <= req_len_i;
            state_q <= (req_len_i == '0) ? BE_DONE : BE_READ;
          end
        end
        BE_READ: state_q <= BE_WRITE;
        BE_WRITE: begin
          left_q  <= left_q - 1'b1;
          state_q <= (left_q == len_t'(1)) ? BE_DONE : BE_READ;
        end
        BE_DONE: state_q <= BE_IDLE;
        default: state_q <= BE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_ready_o && req_valid_i) begin
      src_q <= req_src_i;
      dst_q <= req_dst_i;
    end else if (state_q == BE_WRITE) begin
      src_q <= src_q + 1'b1;
      dst_q <= dst_q + 1'b1;
    end
  end

  // Every write is a request and follows a read of its word
  assert property (@(posedge clk_i) disable iff (rst_i)
    mem_we_o |-> mem_req_o && $past(mem_req_o && !mem_we_o));

endmodule : dma_copy_backend

// ==== source/dma_mem_router.sv ====
`timescale 1ns/1ps

// Address router, sends each access to the TCDM or the external port
module dma_mem_router
  import dma_cfg_pkg::*, dma_xfer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  mem_req_i, mem_we_i,
  input  addr_t mem_addr_i,
  input  data_t mem_wdata_i,
  output data_t mem_rdata_o,
  output logic  tcdm_req_o, tcdm_we_o,
  output addr_t tcdm_addr_o,
  output data_t tcdm_wdata_o,
  input  data_t tcdm_rdata_i,
  output logic  ext_req_o, ext_we_o,
  output addr_t ext_addr_o,
  output data_t ext_wdata_o,
  input  data_t ext_rdata_i
);

  logic in_tcdm;
  logic rd_tcdm_q;

  assign in_tcdm = (mem_addr_i >= TCDM_BASE) && (mem_addr_i < TCDM_BASE + TCDM_SIZE);

  assign tcdm_req_o   = mem_req_i & in_tcdm;
  assign tcdm_we_o    = mem_we_i;
  assign tcdm_addr_o  = mem_addr_i;
  assign tcdm_wdata_o = mem_wdata_i;
  assign ext_req_o    = mem_req_i & ~in_tcdm;
  assign ext_we_o     = mem_we_i;
  assign ext_addr_o   = mem_addr_i;
  assign ext_wdata_o  = mem_wdata_i;

  // Remember which port a read went to, data follows one cycle later
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_tcdm_q <= 1'b0;
    end else if (mem_req_i && !mem_we_i) begin
      rd_tcdm_q <= in_tcdm;
    end
  end

  assign mem_rdata_o = rd_tcdm_q ? tcdm_rdata_i : ext_rdata_i;

  assert property (@(posedge clk_i) disable iff (rst_i) !(tcdm_req_o && ext_req_o));

endmodule : dma_mem_router

// ==== source/fc_dma_top.sv ====
`timescale 1ns/1ps

// Fabric controller DMA top level
// Frontend, descriptor FIFO, 2D midend, copy backend and address router
module fc_dma_top
  import dma_cfg_pkg::*, dma_xfer_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      reg_wr_i,
  input  logic      reg_rd_i,
  input  reg_addr_t reg_addr_i,
  input  data_t     reg_wdata_i,
  output data_t     reg_rdata_o,
  output logic      tcdm_req_o, tcdm_we_o,
  output addr_t     tcdm_addr_o,
  output data_t     tcdm_wdata_o,
  input  data_t     tcdm_rdata_i,
  output logic      ext_req_o, ext_we_o,
  output addr_t     ext_addr_o,
  output data_t     ext_wdata_o,
  input  data_t     ext_rdata_i,
  output logic      term_event_o,
  output logic      busy_o
);

  addr_t fe_src, fe_dst, fe_src_stride, fe_dst_stride;
  len_t  fe_len;
  reps_t fe_reps;
  id_t   fe_id;
  logic  fe_valid, fe_ready;
  addr_t q_src, q_dst, q_src_stride, q_dst_stride;
  len_t  q_len;
  reps_t q_reps;
  id_t   q_id;
  logic  q_valid, q_ready, q_empty;
  addr_t b_src, b_dst;
  len_t  b_len;
  logic  b_valid, b_ready, b_done;
  logic  xfer_done, mid_idle, be_idle;
  id_t   xfer_id;
  logic  m_req, m_we;
  addr_t m_addr;
  data_t m_wdata, m_rdata;

  assign term_event_o = xfer_done;
  assign busy_o       = ~q_empty | ~mid_idle | ~be_idle;

  // ------------------------------------------------------------------
  // Frontend and descriptor FIFO
  // ------------------------------------------------------------------
  dma_reg_frontend i_frontend (
    .clk_i, .rst_i, .reg_wr_i, .reg_rd_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .desc_src_o        ( fe_src        ),
    .desc_dst_o        ( fe_dst        ),
    .desc_src_stride_o ( fe_src_stride ),
    .desc_dst_stride_o ( fe_dst_stride ),
    .desc_len_o        ( fe_len        ),
    .desc_reps_o       ( fe_reps       ),
    .desc_id_o         ( fe_id         ),
    .desc_valid_o      ( fe_valid      ),
    .desc_ready_i      ( fe_ready      ),
    .done_i            ( xfer_done     ),
    .done_id_i         ( xfer_id       )
  );

  dma_req_queue i_queue (
    .clk_i, .rst_i,
    .in_src_i  ( fe_src  ), .in_dst_i ( fe_dst ),
    .in_src_stride_i ( fe_src_stride ), .in_dst_stride_i ( fe_dst_stride ),
    .in_len_i  ( fe_len  ), .in_reps_i ( fe_reps ), .in_id_i ( fe_id ),
    .in_valid_i ( fe_valid ), .in_ready_o ( fe_ready ),
    .out_src_o ( q_src ), .out_dst_o ( q_dst ),
    .out_src_stride_o ( q_src_stride ), .out_dst_stride_o ( q_dst_stride ),
    .out_len_o ( q_len ), .out_reps_o ( q_reps ), .out_id_o ( q_id ),
    .out_valid_o ( q_valid ), .out_ready_i ( q_ready ),
    .empty_o   ( q_empty )
  );

  // ------------------------------------------------------------------
  // Midend, backend and port routing
  // ------------------------------------------------------------------
  dma_2d_midend i_midend (
    .clk_i, .rst_i,
    .nd_src_i  ( q_src ), .nd_dst_i ( q_dst ),
    .nd_src_stride_i ( q_src_stride ), .nd_dst_stride_i ( q_dst_stride ),
    .nd_len_i  ( q_len ), .nd_reps_i ( q_reps ), .nd_id_i ( q_id ),
    .nd_valid_i ( q_valid ), .nd_ready_o ( q_ready ),
    .burst_src_o ( b_src ), .burst_dst_o ( b_dst ), .burst_len_o ( b_len ),
    .burst_valid_o ( b_valid ), .burst_ready_i ( b_ready ),
    .burst_done_i ( b_done ),
    .xfer_done_o ( xfer_done ), .xfer_id_o ( xfer_id ),
    .idle_o      ( mid_idle  )
  );

  dma_copy_backend i_backend (
    .clk_i, .rst_i,
    .req_src_i ( b_src ), .req_dst_i ( b_dst ), .req_len_i ( b_len ),
    .req_valid_i ( b_valid ), .req_ready_o ( b_ready ),
    .done_o      ( b_done  ),
    .mem_req_o ( m_req ), .mem_we_o ( m_we ), .mem_addr_o ( m_addr ),
    .mem_wdata_o ( m_wdata ), .mem_rdata_i ( m_rdata ),
    .idle_o      ( be_idle )
  );

  dma_mem_router i_router (
    .clk_i, .rst_i,
    .mem_req_i ( m_req ), .mem_we_i ( m_we ), .mem_addr_i ( m_addr ),
    .mem_wdata_i ( m_wdata ), .mem_rdata_o ( m_rdata ),
    .tcdm_req_o, .tcdm_we_o, .tcdm_addr_o, .tcdm_wdata_o, .tcdm_rdata_i,
    .ext_req_o, .ext_we_o, .ext_addr_o, .ext_wdata_o, .ext_rdata_i
  );

endmodule : fc_dma_top

// ==== tests/fc_dma_tb.sv ====
`timescale 1ns/1ps

// Testbench for the fabric controller DMA
// Two 1-cycle memory models, a register driver and checking assertions
module fc_dma_tb
  import dma_cfg_pkg::*, dma_xfer_pkg::*;
();

  localparam int unsigned HALF_PERIOD  = 10;
  localparam int unsigned MEM_WORDS    = 256;
  localparam addr_t       EXT_BASE     = 32'h0004_0000;
  localparam int unsigned Q_LEN        = 8;
  localparam int unsigned Q_REPS       = 2;
  // Words moved by the 1D, 2D and queue tests
  localparam int unsigned TOTAL_WORDS  = 10 + 5 * 3 + (QUEUE_DEPTH + 1) * Q_LEN * Q_REPS;
  localparam int unsigned WATCHDOG_CYC = TOTAL_WORDS * 4 + 1000;
  localparam int unsigned TERM_TIMEOUT = 500;

  logic      clk = 1'b0;
  logic      rst;
  logic      reg_wr, reg_rd;
  reg_addr_t reg_addr;
  data_t     reg_wdata, reg_rdata;
  logic      tcdm_req, tcdm_we, ext_req, ext_we;
  addr_t     tcdm_addr, ext_addr;
  data_t     tcdm_wdata, ext_wdata;
  data_t     tcdm_rdata = '0;
  data_t     ext_rdata = '0;
  logic      term_event, busy;

  data_t tcdm_mem [MEM_WORDS];
  data_t ext_mem  [MEM_WORDS];
  data_t ref_tcdm [MEM_WORDS];
  data_t ref_ext  [MEM_WORDS];

  integer seed = 32'hbf7a;
  int     err_count = 0;
  int     check_count = 0;
  int     pending = 0;
  logic   launched = 1'b0;
  logic   launch_q = 1'b0;
  logic   zero_active = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

  fc_dma_top dut (
    .clk_i (clk), .rst_i (rst),
    .reg_wr_i (reg_wr), .reg_rd_i (reg_rd), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_rdata_o (reg_rdata),
    .tcdm_req_o (tcdm_req), .tcdm_we_o (tcdm_we), .tcdm_addr_o (tcdm_addr),
    .tcdm_wdata_o (tcdm_wdata), .tcdm_rdata_i (tcdm_rdata),
    .ext_req_o (ext_req), .ext_we_o (ext_we), .ext_addr_o (ext_addr),
    .ext_wdata_o (ext_wdata), .ext_rdata_i (ext_rdata),
    .term_event_o (term_event), .busy_o (busy)
  );

  // ------------------------------------------------------------------
  // Address decode and reference model
  // ------------------------------------------------------------------
  function automatic logic in_window(addr_t a);
    return (a >= TCDM_BASE) && (a < TCDM_BASE + TCDM_SIZE);
  endfunction

  // Both memories keep the low byte of the offset from their base
  function automatic logic [7:0] tcdm_index(addr_t a);
    addr_t off;
    off = a - TCDM_BASE;
    return off[7:0];
  endfunction

  function automatic logic [7:0] ext_index(addr_t a);
    addr_t off;
    off = a - EXT_BASE;
    return off[7:0];
  endfunction

  function automatic data_t ref_read(addr_t a);
    return in_window(a) ? ref_tcdm[tcdm_index(a)] : ref_ext[ext_index(a)];
  endfunction

  // Burst r starts at the base plus r strides, reps of 0 moves one burst
  task automatic model_copy(addr_t src, addr_t dst, addr_t src_stride, addr_t dst_stride,
                            int unsigned len, int unsigned reps);
    int unsigned n_reps;
    addr_t       s;
    addr_t       d;
    n_reps = (reps == 0) ? 1 : reps;
    for (int unsigned r = 0; r < n_reps; r++) begin
      for (int unsigned w = 0; w < len; w++) begin
        s = src + r * src_stride + w;
        d = dst + r * dst_stride + w;
        if (in_window(d)) begin
          ref_tcdm[tcdm_index(d)] = ref_read(s);
        end else begin
          ref_ext[ext_index(d)] = ref_read(s);
        end
      end
    end
  endtask

  // Memory models, read data one cycle after the strobe
  always @(posedge clk) begin
    if (tcdm_req && tcdm_we) begin
      tcdm_mem[tcdm_index(tcdm_addr)] <= tcdm_wdata;
    end else if (tcdm_req) begin
      tcdm_rdata <= tcdm_mem[tcdm_index(tcdm_addr)];
    end
  end

  always @(posedge clk) begin
    if (ext_req && ext_we) begin
      ext_mem[ext_index(ext_addr)] <= ext_wdata;
    end else if (ext_req) begin
      ext_rdata <= ext_mem[ext_index(ext_addr)];
    end
  end

  // Transfers launched but not yet ended
  always @(posedge clk) begin
    if (rst) begin
      pending  <= 0;
      launch_q <= 1'b0;
    end else begin
      pending  <= pending + (launched ? 1 : 0) - (term_event ? 1 : 0);
      launch_q <= launched;
    end
  end

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------
  a_one_port: assert property (@(posedge clk) disable iff (rst) !(tcdm_req && ext_req))
    else begin
      err_count++;
      $display("Both memory ports strobed in the same cycle");
    end

  a_tcdm_route: assert property (@(posedge clk) disable iff (rst)
    tcdm_req |-> in_window(tcdm_addr))
    else begin
      err_count++;
      $display("TCDM strobe at address %h outside the TCDM window", tcdm_addr);
    end

  a_ext_route: assert property (@(posedge clk) disable iff (rst)
    ext_req |-> !in_window(ext_addr))
    else begin
      err_count++;
      $display("External strobe at address %h inside the TCDM window", ext_addr);
    end

  a_zero_len: assert property (@(posedge clk) disable iff (rst)
    zero_active |-> !(tcdm_req || ext_req))
    else begin
      err_count++;
      $display("Memory strobe during a zero-length transfer");
    end

  // The descriptor spends the cycle after launch on its way into the FIFO
  a_busy_high: assert property (@(posedge clk) disable iff (rst)
    (pending != 0 && !launch_q && !term_event) |-> busy)
    else begin
      err_count++;
      $display("busy_o low while %0d transfers are outstanding", pending);
    end

  a_busy_low: assert property (@(posedge clk) disable iff (rst) (pending == 0) |-> !busy)
    else begin
      err_count++;
      $display("busy_o high with no transfer outstanding");
    end

  // ------------------------------------------------------------------
  // Register driver and checks
  // ------------------------------------------------------------------
  task automatic check_value(string name, data_t expected, data_t actual);
    check_count++;
    assert (actual === expected)
      else begin
        err_count++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      end
  endtask

  task automatic reg_write(reg_addr_t addr, data_t data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(reg_addr_t addr, output data_t data);
    @(negedge clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    #(HALF_PERIOD / 2);
    data = reg_rdata;
    // A nonzero id means the transfer starts on the coming edge
    launched = (addr == REG_NEXT_ID) && (data != '0);
    @(negedge clk);
    reg_rd   = 1'b0;
    launched = 1'b0;
  endtask

  task automatic program_xfer(addr_t src, addr_t dst, addr_t src_stride,
                              addr_t dst_stride, data_t len, data_t reps);
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_SRC_STRIDE, src_stride);
    reg_write(REG_DST_STRIDE, dst_stride);
    reg_write(REG_LEN, len);
    reg_write(REG_REPS, reps);
  endtask

  task automatic launch(string name, data_t expected);
    data_t id;
    reg_read(REG_NEXT_ID, id);
    check_value({name, " launch id"}, expected, id);
  endtask

  task automatic wait_term(string name, data_t id);
    int unsigned cycles;
    data_t       done_id;
    cycles = 0;
    while (!term_event && cycles < TERM_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!term_event) begin
      err_count++;
      $display("%s: no completion event within %0d cycles", name, TERM_TIMEOUT);
    end else begin
      reg_read(REG_DONE_ID, done_id);
      check_value({name, " done id"}, id, done_id);
    end
  endtask

  task automatic compare_mems(string name);
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value($sformatf("%s tcdm[%0d]", name, i), ref_tcdm[i], tcdm_mem[i]);
      check_value($sformatf("%s ext[%0d]", name, i), ref_ext[i], ext_mem[i]);
    end
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    data_t v;
    rst       = 1'b1;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      v = $random(seed) ^ (TCDM_BASE + i);
      tcdm_mem[i] <= v;
      ref_tcdm[i] = v;
      v = $random(seed) ^ (EXT_BASE + i);
      ext_mem[i] <= v;
      ref_ext[i] = v;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("reset outputs", '0, {28'd0, term_event, busy, tcdm_req, ext_req});

    // 1D copy, external to TCDM
    program_xfer(EXT_BASE + 8, TCDM_BASE + 16, 0, 0, 10, 1);
    model_copy(EXT_BASE + 8, TCDM_BASE + 16, 0, 0, 10, 1);
    launch("1d_copy", 1);
    wait_term("1d_copy", 1);
    compare_mems("1d_copy");

    // 2D copy, TCDM to external with distinct strides
    program_xfer(TCDM_BASE + 64, EXT_BASE + 100, 12, 20, 5, 3);
    model_copy(TCDM_BASE + 64, EXT_BASE + 100, 12, 20, 5, 3);
    launch("2d_copy", 2);
    wait_term("2d_copy", 2);
    compare_mems("2d_copy");

    zero_active = 1'b1;
    program_xfer(EXT_BASE + 30, TCDM_BASE + 40, 0, 0, 0, 0);
    launch("zero_len", 3);
    wait_term("zero_len", 3);
    zero_active = 1'b0;
    compare_mems("zero_len");

    // One transfer in the midend plus a full FIFO, then a refused launch
    program_xfer(EXT_BASE + 200, TCDM_BASE + 200, 8, 10, Q_LEN, Q_REPS);
    model_copy(EXT_BASE + 200, TCDM_BASE + 200, 8, 10, Q_LEN, Q_REPS);
    for (int k = 0; k <= QUEUE_DEPTH; k++) begin
      launch("queue_fill", data_t'(4 + k));
    end
    launch("queue_full", 0);
    for (int k = 0; k <= QUEUE_DEPTH; k++) begin
      wait_term("queue_order", data_t'(4 + k));
    end
    compare_mems("queue");

    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYC);
    $display("Test failures found");
    $finish;
  end

endmodule : fc_dma_tb

// ==== fc_dma.f ====
source/dma_cfg_pkg.sv
source/dma_xfer_pkg.sv
source/dma_reg_frontend.sv
source/dma_req_queue.sv
source/dma_2d_midend.sv
source/dma_copy_backend.sv
source/dma_mem_router.sv
source/fc_dma_top.sv
tests/fc_dma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := fc_dma_tb
FILELIST  := fc_dma.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
